// ==== flist.f ====
src/isaPkg.sv
src/bundlePkg.sv
src/boundaryFinder.sv
src/instrClassifier.sv
src/prefixCounter.sv
src/slotCompactor.sv
src/predecodeOutReg.sv
src/predecodeTop.sv
tb/predecodeCheck_sva.sv
tb/predecodeTb.sv

// ==== Makefile ====
# Verilator build and run for the fetch bundle predecoder

VERILATOR ?= verilator
TOP       ?= predecodeTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/predecodeTb.sv ====
//============================================================
// Predecoder testbench
// clock and reset, random and directed bundles,
// reference model and output comparator
//============================================================
`timescale 1ns/1ps
`default_nettype none

module predecodeTb;
  import bundlePkg::*;
  import isaPkg::*;

  typedef struct packed {
    instrSlotT [slotCount-1:0]     slots;
    logic [slotCount-1:0]          slotEn;
    instrSlotT [jumpSlotCount-1:0] jumpSlots;
    logic [jumpSlotCount-1:0]      jumpEn;
    rankT                          instrCount;
    logic                          error;
    logic                          jumpError;
  } expT;

  localparam int resetCycles = 16;
  localparam int waitLimit   = 40;  // longer than reset and any idle gap

  logic                          clk = 1'b0;
  logic                          rstN = 1'b0;
  logic                          bundleValid = 1'b0;
  bundleT                        bundle = '0;
  parcelMaskT                    endMask = '0;
  parcelIdxT                     startOff = '0;
  logic                          outValid;
  instrSlotT [slotCount-1:0]     slots;
  logic [slotCount-1:0]          slotEn;
  instrSlotT [jumpSlotCount-1:0] jumpSlots;
  logic [jumpSlotCount-1:0]      jumpEn;
  rankT                          instrCount;
  logic                          error;
  logic                          jumpError;

  expT lastExp = '0;  // all zero out of reset
  expT expQ[$];
  int  strobeQ[$];  // cycle of each strobe
  int  cycleCnt = 0;
  int  sentCount = 0;
  int  doneCount = 0;
  int  checkCount = 0;
  int  errorCount = 0;
  int  subCodes[10] = '{0, 15, 16, 31, 32, 47, 48, 51, 52, 63};
  int  opCodes[28] = '{0, 3, 4, 31, 32, 39, 40, 45, 46, 63, 64, 65, 126, 127, 128, 159,
                      160, 175, 176, 180, 181, 182, 183, 239, 240, 243, 244, 255};

  predecodeTop dut_i (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  function automatic instrClassT classOf(input logic [15:0] first, input int len);
    instrClassT c;
    c = '0;
    if (len == 1) begin
      c.alu   = first[5:0] <= subAluHi;
      c.shift = first[5:0] > subAluHi && first[5:0] <= subShiftHi;
      c.jump  = first[5:0] inside {[subJumpLo:subJumpHi]};
    end else begin
      case (first[7:0]) inside
        [opAluLo:opAluHi]: begin
          c.mul = first[2];
          c.alu = ~first[2];
        end
        [opShiftLo:opShiftHi]: c.shift = 1'b1;
        [opMemLo:opMemHi]: begin
          c.store = first[0];
          c.load  = ~first[0];
        end
        [opCondJumpLo:opCondJumpHi], opJump: c.jump = 1'b1;
        opIndirJump: begin
          c.jump  = 1'b1;
          c.indir = 1'b1;
        end
        [opFpuLo:opFpuHi]: c.fpu = 1'b1;
        opSys: c.sys = 1'b1;
        default: c = '0;  // undefined codes
      endcase
    end
    return c;
  endfunction

  function automatic expT predictOutputs(input bundleT b, input parcelMaskT em,
                                         input parcelIdxT so);
    expT       e;
    instrSlotT item;
    int        n;
    int        nj;
    int        len;
    e  = '0;
    n  = 0;
    nj = 0;
    for (int k = 0; k < parcelCount; k++) begin
      len = 0;
      for (int d = 0; d < maxInstrParcels; d++) begin
        if (len == 0 && k + d < parcelCount && em[k+d]) len = d + 1;  // nearest end
      end
      if ((k == 0 || em[k-1]) && k >= int'(so) && len != 0) begin
        item = '0;
        for (int j = 0; j < maxInstrParcels && k + j < parcelCount; j++) begin
          item.window[j*parcelWidth +: parcelWidth] = b[(k+j)*parcelWidth +: parcelWidth];
        end
        item.cls = classOf(b[k*parcelWidth +: parcelWidth], len);
        item.len = instrLenT'(len - 1);
        item.off = parcelIdxT'(k);
        if (n < slotCount) begin
          e.slots[n]  = item;
          e.slotEn[n] = 1'b1;
        end
        if (item.cls.jump && nj < jumpSlotCount) begin
          e.jumpSlots[nj] = item;
          e.jumpEn[nj]    = 1'b1;
        end
        n  = n + 1;
        nj = nj + int'(item.cls.jump);
      end
    end
    e.instrCount = rankT'(n);
    e.error      = n > slotCount;
    e.jumpError  = nj > jumpSlotCount;
    return e;
  endfunction

  task automatic checkField(input string name, input logic [127:0] got,
                            input logic [127:0] want);
    checkCount++;
    assert (got === want) else begin
      errorCount++;
      $display("** Error: %s got %0h expected %0h (cycle %0d)", name, got, want, cycleCnt);
    end
  endtask

  task automatic compareOutputs(input expT e);
    for (int i = 0; i < slotCount; i++) begin
      checkField($sformatf("slots[%0d]", i), 128'(slots[i]), 128'(e.slots[i]));
    end
    for (int i = 0; i < jumpSlotCount; i++) begin
      checkField($sformatf("jumpSlots[%0d]", i), 128'(jumpSlots[i]), 128'(e.jumpSlots[i]));
    end
    checkField("slotEn", 128'(slotEn), 128'(e.slotEn));
    checkField("jumpEn", 128'(jumpEn), 128'(e.jumpEn));
    checkField("instrCount", 128'(instrCount), 128'(e.instrCount));
    checkField("error", 128'(error), 128'(e.error));
    checkField("jumpError", 128'(jumpError), 128'(e.jumpError));
  endtask

  function automatic bundleT randomBundle();
    bundleT b;
    for (int i = 0; i < parcelCount / 2; i++) b[i*32 +: 32] = $urandom;
    return b;
  endfunction

  task automatic sendBundle(input bundleT b, input parcelMaskT em, input parcelIdxT so);
    @(posedge clk);
    bundleValid <= 1'b1;
    bundle      <= b;
    endMask     <= em;
    startOff    <= so;
    expQ.push_back(predictOutputs(b, em, so));
    strobeQ.push_back(cycleCnt + 1);
    sentCount++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      bundleValid <= 1'b0;
    end
  endtask

  initial begin : stimulus
    bundleT b;
    int     waited;
    void'($urandom(32'h897e));
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    idle(2);
    for (int i = 0; i < 12; i++) begin  // bursts of four with growing gaps
      sendBundle(randomBundle(), parcelMaskT'($urandom), '0);
      if (i % 4 == 3) idle(i / 4 + 1);
    end
    for (int i = 0; i < 60; i++) sendBundle(randomBundle(), parcelMaskT'($urandom), '0);
    for (int i = 0; i < 60; i++) begin
      sendBundle(randomBundle(), parcelMaskT'($urandom), parcelIdxT'($urandom));
      if ($urandom % 4 == 0) idle(1);
    end
    foreach (subCodes[c]) begin
      b = randomBundle();
      for (int p = 0; p < parcelCount; p++) b[p*parcelWidth +: 6] = 6'(subCodes[c]);
      sendBundle(b, '1, '0);
    end
    foreach (opCodes[c]) begin
      b = randomBundle();
      for (int p = 0; p < parcelCount; p++) b[p*parcelWidth +: 8] = 8'(opCodes[c]);
      sendBundle(b, 16'h894a, '0);  // lengths 2 2 3 2 3 4
    end
    for (int n = 0; n <= 5; n++) begin  // n jumps among eight short instructions
      b = randomBundle();
      for (int p = 8; p < parcelCount; p++) begin
        b[p*parcelWidth +: 6] = (p >= parcelCount - n) ? 6'(48 + $urandom % 4)
                                                       : 6'($urandom % 16);
      end
      sendBundle(b, '1, parcelIdxT'(8));
    end
    for (int m = 9; m <= parcelCount; m++) begin
      b = randomBundle();
      for (int p = 0; p < parcelCount; p++) b[p*parcelWidth +: 6] = 6'($urandom % 32);
      sendBundle(b, '1, parcelIdxT'(parcelCount - m));
    end
    idle(3);
    waited = 0;
    while (doneCount < sentCount && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (doneCount < sentCount) begin
      $display("timeout: %0d bundles never came out", sentCount - doneCount);
    end
    $display("checks %0d, errors %0d, bundles %0d", checkCount, errorCount, sentCount);
    if (errorCount == 0 && doneCount == sentCount) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

  // oldest prediction against each outValid pulse
  initial begin : comparator
    int  waited;
    bit  timedOut;
    expT e;
    timedOut = 1'b0;
    while (!timedOut) begin
      waited = 0;
      @(negedge clk);
      while (!outValid && waited < waitLimit) begin
        compareOutputs(lastExp);  // outputs hold between strobes
        @(negedge clk);
        waited++;
      end
      if (!outValid) begin
        timedOut = 1'b1;
      end else begin
        assert (expQ.size() != 0) else begin
          errorCount++;
          $display("outValid pulsed with no bundle outstanding");
        end
        if (expQ.size() != 0) begin
          e = expQ.pop_front();
          checkField("outValid cycle", 128'(cycleCnt), 128'(strobeQ.pop_front() + 1));
          compareOutputs(e);
          lastExp = e;
          doneCount++;
        end
      end
    end
    $display("timeout: no outValid within %0d cycles", waitLimit);
    $display("checks %0d, errors %0d, bundles %0d", checkCount, errorCount, sentCount);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/predecodeCheck_sva.sv ====
//============================================================
// Bound checks on the predecoder top level
// strobe latency, quiet reset, overflow flag
//============================================================
`timescale 1ns/1ps
`default_nettype none

module predecodeCheck (
  input logic            clk,
  input logic            rstN,
  input logic            bundleValid,
  input logic            outValid,
  input logic            error,
  input bundlePkg::rankT instrCount
);
  import bundlePkg::*;

  strobeLatency: assert property (@(posedge clk) $past(rstN) |-> outValid == $past(bundleValid))
    else $error("outValid does not follow bundleValid by one cycle");

  resetQuiet: assert property (@(posedge clk) !rstN |=> !outValid)
    else $error("outValid high after a reset cycle");

  // only a real overflow may raise error
  overflowFlag: assert property (@(posedge clk) disable iff (!rstN)
      error |-> instrCount > rankT'(slotCount))
    else $error("error set without slot overflow");

endmodule

bind predecodeTop predecodeCheck check_i (
  .clk(clk), .rstN(rstN), .bundleValid(bundleValid), .outValid(outValid),
  .error(error), .instrCount(instrCount)
);

`default_nettype wire

// ==== src/predecodeTop.sv ====
//============================================================
// Fetch bundle predecoder, top level
// boundary finder, per-parcel classifiers, rank counters,
// slot compactors and the output register
//============================================================
`timescale 1ns/1ps
`default_nettype none

module predecodeTop (
  input  logic                                                clk,
  input  logic                                                rstN,
  input  logic                                                bundleValid,
  input  bundlePkg::bundleT                                   bundle,
  input  bundlePkg::parcelMaskT                               endMask,
  input  bundlePkg::parcelIdxT                                startOff,
  output logic                                                outValid,
  output bundlePkg::instrSlotT [bundlePkg::slotCount-1:0]     slots,
  output logic [bundlePkg::slotCount-1:0]                     slotEn,
  output bundlePkg::instrSlotT [bundlePkg::jumpSlotCount-1:0] jumpSlots,
  output logic [bundlePkg::jumpSlotCount-1:0]                 jumpEn,
  output bundlePkg::rankT                                     instrCount,
  output logic                                                error,
  output logic                                                jumpError
);
  import bundlePkg::*;

  parcelMaskT                           validStart;
  parcelMaskT                           jumpMask;
  instrLenT [parcelCount-1:0]           lens;
  isaPkg::instrClassT [parcelCount-1:0] classes;
  instrSlotT [parcelCount-1:0]          items;
  rankT [parcelCount-1:0]               instrRanks;
  rankT [parcelCount-1:0]               jumpRanks;
  rankT                                 instrTotal;
  rankT                                 jumpTotal;
  instrSlotT [slotCount-1:0]            cmpSlots;
  logic [slotCount-1:0]                 cmpSlotEn;
  instrSlotT [jumpSlotCount-1:0]        cmpJumpSlots;
  logic [jumpSlotCount-1:0]             cmpJumpEn;
  logic [(parcelCount+maxInstrParcels-1)*parcelWidth-1:0] bundleExt;

  // zero parcels past the end of the bundle
  assign bundleExt = {{((maxInstrParcels-1)*parcelWidth){1'b0}}, bundle};

  boundaryFinder finder_i (.endMask(endMask), .startOff(startOff),
                           .validStart(validStart), .lens(lens));

  for (genvar k = 0; k < parcelCount; k++) begin : parcelGen
    instrClassifier cls_i (
      .window(bundleExt[k*parcelWidth +: maxInstrParcels*parcelWidth]),
      .len   (lens[k]),
      .cls   (classes[k])
    );
    assign items[k] = '{cls: classes[k],
                        window: bundleExt[k*parcelWidth +: maxInstrParcels*parcelWidth],
                        len: lens[k], off: parcelIdxT'(k)};
    assign jumpMask[k] = validStart[k] & classes[k].jump;
  end

  prefixCounter instrCnt_i (.flags(validStart), .ranks(instrRanks), .total(instrTotal));
  prefixCounter jumpCnt_i (.flags(jumpMask), .ranks(jumpRanks), .total(jumpTotal));

  slotCompactor #(.numSlots(slotCount)) slotCmp_i (.items(items), .sel(validStart),
    .ranks(instrRanks), .slotsOut(cmpSlots), .slotEn(cmpSlotEn));
  slotCompactor #(.numSlots(jumpSlotCount)) jumpCmp_i (.items(items), .sel(jumpMask),
    .ranks(jumpRanks), .slotsOut(cmpJumpSlots), .slotEn(cmpJumpEn));

  predecodeOutReg outReg_i (
    .clk(clk), .rstN(rstN), .bundleValid(bundleValid),
    .nextSlots(cmpSlots), .nextSlotEn(cmpSlotEn),
    .nextJumpSlots(cmpJumpSlots), .nextJumpEn(cmpJumpEn),
    .nextCount(instrTotal), .jumpTotal(jumpTotal),
    .outValid(outValid), .slots(slots), .slotEn(slotEn),
    .jumpSlots(jumpSlots), .jumpEn(jumpEn), .instrCount(instrCount),
    .error(error), .jumpError(jumpError)
  );

endmodule

`default_nettype wire

// ==== src/predecodeOutReg.sv ====
//============================================================
// Predecoder output stage
// captures slots and counts on a strobe, derives
// the overflow flags and the output strobe
//============================================================
`timescale 1ns/1ps
`default_nettype none

module predecodeOutReg (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  logic                                             bundleValid,
  input  bundlePkg::instrSlotT [bundlePkg::slotCount-1:0]     nextSlots,
  input  logic [bundlePkg::slotCount-1:0]                     nextSlotEn,
  input  bundlePkg::instrSlotT [bundlePkg::jumpSlotCount-1:0] nextJumpSlots,
  input  logic [bundlePkg::jumpSlotCount-1:0]                 nextJumpEn,
  input  bundlePkg::rankT                                     nextCount,
  input  bundlePkg::rankT                                     jumpTotal,
  output logic                                                outValid,
  output bundlePkg::instrSlotT [bundlePkg::slotCount-1:0]     slots,
  output logic [bundlePkg::slotCount-1:0]                     slotEn,
  output bundlePkg::instrSlotT [bundlePkg::jumpSlotCount-1:0] jumpSlots,
  output logic [bundlePkg::jumpSlotCount-1:0]                 jumpEn,
  output bundlePkg::rankT                                     instrCount,
  output logic                                                error,
  output logic                                                jumpError
);
  import bundlePkg::*;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid   <= 1'b0;
      slots      <= '0;
      slotEn     <= '0;
      jumpSlots  <= '0;
      jumpEn     <= '0;
      instrCount <= '0;
      error      <= 1'b0;
      jumpError  <= 1'b0;
    end else begin
      outValid <= bundleValid;  // one-cycle pulse
      if (bundleValid) begin
        slots      <= nextSlots;
        slotEn     <= nextSlotEn;
        jumpSlots  <= nextJumpSlots;
        jumpEn     <= nextJumpEn;
        instrCount <= nextCount;
        error      <= nextCount > rankT'(slotCount);      // tail dropped
        jumpError  <= jumpTotal > rankT'(jumpSlotCount);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/slotCompactor.sv ====
//============================================================
// Slot compactor
// AND-OR mux per slot, picks the selected parcel
// whose rank equals the slot number
//============================================================
`timescale 1ns/1ps
`default_nettype none

module slotCompactor #(
  parameter int numSlots = 8
) (
  input  bundlePkg::instrSlotT [bundlePkg::parcelCount-1:0] items,
  input  bundlePkg::parcelMaskT                             sel,
  input  bundlePkg::rankT [bundlePkg::parcelCount-1:0]      ranks,
  output bundlePkg::instrSlotT [numSlots-1:0]               slotsOut,
  output logic [numSlots-1:0]                               slotEn
);
  import bundlePkg::*;

  always_comb begin
    logic hit;
    slotsOut = '0;
    slotEn   = '0;
    for (int s = 0; s < numSlots; s++) begin
      for (int k = 0; k < parcelCount; k++) begin
        // ranks are unique among selected parcels
        hit         = sel[k] && (ranks[k] == rankT'(s));
        slotsOut[s] = slotsOut[s] | (items[k] & {$bits(instrSlotT){hit}});
        slotEn[s]   = slotEn[s] | hit;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/prefixCounter.sv ====
//============================================================
// Prefix counter
// rank of each flagged parcel and total flag count
//============================================================
`timescale 1ns/1ps
`default_nettype none

module prefixCounter (
  input  bundlePkg::parcelMaskT                       flags,
  output bundlePkg::rankT [bundlePkg::parcelCount-1:0] ranks,
  output bundlePkg::rankT                             total
);
  import bundlePkg::*;

  rankT acc;

  always_comb begin
    acc = '0;
    for (int k = 0; k < parcelCount; k++) begin
      ranks[k] = acc;  // flags strictly below k
      acc      = acc + rankT'(flags[k]);
    end
    total = acc;
  end

endmodule

`default_nettype wire

// ==== src/instrClassifier.sv ====
//============================================================
// Instruction classifier
// one-parcel forms decode the sub-opcode,
// longer forms decode the main opcode
//============================================================
`timescale 1ns/1ps
`default_nettype none

module instrClassifier (
  input  bundlePkg::instrWinT   window,
  input  bundlePkg::instrLenT   len,
  output isaPkg::instrClassT    cls
);
  import isaPkg::*;

  opcodeT opcode;
  subOpT  subOp;

  function automatic logic inRange(input opcodeT code, input opcodeT lo, input opcodeT hi);
    return (code >= lo) && (code <= hi);
  endfunction

  assign opcode = window[7:0];
  assign subOp  = window[5:0];

  always_comb begin
    cls = '0;
    if (len == '0) begin
      // short forms
      if (subOp <= subAluHi) begin
        cls.alu = 1'b1;
      end else if (subOp <= subShiftHi) begin
        cls.shift = 1'b1;
      end else if (subOp >= subJumpLo && subOp <= subJumpHi) begin
        cls.jump = 1'b1;
      end
    end else begin
      if (inRange(opcode, opAluLo, opAluHi)) begin
        cls.mul = opcode[2];
        cls.alu = ~opcode[2];
      end else if (inRange(opcode, opShiftLo, opShiftHi)) begin
        cls.shift = 1'b1;
      end else if (inRange(opcode, opMemLo, opMemHi)) begin
        cls.store = opcode[0];  // odd opcodes store
        cls.load  = ~opcode[0];
      end else if (inRange(opcode, opCondJumpLo, opCondJumpHi) || opcode == opJump) begin
        cls.jump = 1'b1;
      end else if (opcode == opIndirJump) begin
        cls.jump  = 1'b1;
        cls.indir = 1'b1;
      end else if (inRange(opcode, opFpuLo, opFpuHi)) begin
        cls.fpu = 1'b1;
      end else if (opcode == opSys) begin
        cls.sys = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/boundaryFinder.sv ====
//============================================================
// Instruction boundary finder
// start marks from the end mask, offset masking,
// completeness check and length of each instruction
//============================================================
`timescale 1ns/1ps
`default_nettype none

module boundaryFinder (
  input  bundlePkg::parcelMaskT                          endMask,
  input  bundlePkg::parcelIdxT                           startOff,
  output bundlePkg::parcelMaskT                          validStart,
  output bundlePkg::instrLenT [bundlePkg::parcelCount-1:0] lens
);
  import bundlePkg::*;

  parcelMaskT startMark;
  parcelMaskT offMask;
  parcelMaskT complete;
  logic [parcelCount+maxInstrParcels-2:0] endExt;

  assign startMark = {endMask[parcelCount-2:0], 1'b1};  // parcel 0 always starts
  assign offMask   = {parcelCount{1'b1}} << startOff;
  assign endExt    = {{(maxInstrParcels-1){1'b0}}, endMask};  // no ends past the bundle

  always_comb begin
    complete = '0;
    lens     = '0;
    for (int k = 0; k < parcelCount; k++) begin
      // walk down so the nearest end wins
      for (int d = maxInstrParcels - 1; d >= 0; d--) begin
        if (endExt[k+d]) begin
          complete[k] = 1'b1;
          lens[k]     = instrLenT'(d);
        end
      end
    end
  end

  assign validStart = startMark & offMask & complete;

endmodule

`default_nettype wire

// ==== src/bundlePkg.sv ====
//============================================================
// Fetch bundle geometry
// parcel and slot counts, vector types of the bundle
// and the packed slot record handed to the backend
//============================================================
`default_nettype none

package bundlePkg;

  localparam int parcelCount     = 16;
  localparam int parcelWidth     = 16;
  localparam int maxInstrParcels = 4;
  localparam int slotCount       = 8;
  localparam int jumpSlotCount   = 2;

  // one bit per parcel
  typedef logic [parcelCount-1:0] parcelMaskT;

  typedef logic [$clog2(parcelCount)-1:0] parcelIdxT;

  // length minus one
  typedef logic [$clog2(maxInstrParcels)-1:0] instrLenT;

  // parcels k..k+3, parcel k in the low bits
  typedef logic [maxInstrParcels*parcelWidth-1:0] instrWinT;

  // 0..16, needs one bit more than an index
  typedef logic [$clog2(parcelCount+1)-1:0] rankT;

  typedef logic [parcelCount*parcelWidth-1:0] bundleT;

  typedef struct packed {
    isaPkg::instrClassT cls;
    instrWinT           window;
    instrLenT           len;
    parcelIdxT          off;  // parcel where the instruction starts
  } instrSlotT;

endpackage

`default_nettype wire

// ==== src/isaPkg.sv ====
//============================================================
// ISA encoding definitions for the predecoder
// main opcode and sub-opcode ranges of the reduced table
// class flag struct produced per instruction
//============================================================
`default_nettype none

package isaPkg;

  typedef logic [7:0] opcodeT;  // bits 7..0 of the first parcel
  typedef logic [5:0] subOpT;   // one-parcel forms only

  typedef struct packed {
    logic jump;
    logic indir;  // target comes from a register
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic fpu;
    logic sys;
  } instrClassT;

  // main opcode ranges, multi-parcel instructions
  localparam opcodeT opAluLo      = 8'd0;
  localparam opcodeT opAluHi      = 8'd31;   // bit 2 picks mul
  localparam opcodeT opShiftLo    = 8'd40;
  localparam opcodeT opShiftHi    = 8'd45;
  localparam opcodeT opMemLo      = 8'd64;
  localparam opcodeT opMemHi      = 8'd127;  // bit 0 picks store
  localparam opcodeT opCondJumpLo = 8'd160;
  localparam opcodeT opCondJumpHi = 8'd175;
  localparam opcodeT opJump       = 8'd180;
  localparam opcodeT opIndirJump  = 8'd182;
  localparam opcodeT opFpuLo      = 8'd240;
  localparam opcodeT opFpuHi      = 8'd243;
  localparam opcodeT opSys        = 8'd255;

  // one-parcel sub-opcodes
  localparam subOpT subAluHi   = 6'd15;
  localparam subOpT subShiftHi = 6'd31;
  localparam subOpT subJumpLo  = 6'd48;
  localparam subOpT subJumpHi  = 6'd51;

endpackage

`default_nettype wire
